// ==== filelist.f ====
+incdir+source
source/cpu_pkg.sv
source/axil_pkg.sv
source/mem_stage.sv
source/axil_data_master.sv
source/axil_data_ram.sv
source/mem_subsys_top.sv
testbench/tb_mem_subsys.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the memory subsystem testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing -j 0 \
	--top-module tb_mem_subsys \
	--x-initial 0 \
	-f filelist.f \
	-o tb_mem_subsys_sim

./obj_dir/tb_mem_subsys_sim | tee "$LOG"

if grep -q "^TEST RESULT: PASS$" "$LOG"; then
	echo "Simulation passed"
else
	echo "Simulation failed, see $LOG"
	exit 1
fi

// ==== testbench/tb_mem_subsys.sv ====
`timescale 1ns/1ps
`include "cpu_macros.svh"

module tb_mem_subsys;

	localparam int RAM_WAIT  = `RAM_WAIT_DEFAULT;
	localparam int MEM_BYTES = `RAM_DEPTH_WORDS * 4;  // Model wraps like the RAM

	// One table row with stimulus and expected retire
	typedef struct packed {
		cpu_pkg::mem_op_e            op;
		logic [`CPU_WORD_W-1:0]      addr;
		logic [`CPU_WORD_W-1:0]      wdata;
		logic [`CPU_REG_ADDR_W-1:0]  rd;
		logic                        rd_we;
		logic                        exp_bus;   // Stall expected
		logic                        exp_we;
		logic [`CPU_WORD_W-1:0]      exp_data;
	} row_t;

	logic             clk;
	logic             rst;
	cpu_pkg::ex_mem_t ex_i;
	logic             stall_o;
	cpu_pkg::mem_wb_t wb_o;

	row_t        tbl[$];
	string       tbl_name[$];
	logic [7:0]  ref_mem [MEM_BYTES];  // Byte image of the RAM
	logic [31:0] rng = 32'd89;
	int          errors = 0;
	int          checks = 0;
	int          retires = 0;
	int          cycles = 0;
	int          limit = 0;           // Zero until the table is built

	mem_subsys_top #(
		.RAM_WAIT (RAM_WAIT)
	) dut (
		.clk     (clk),
		.rst     (rst),
		.ex_i    (ex_i),
		.stall_o (stall_o),
		.wb_o    (wb_o)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;             // 4 ns period
	end

	// Xorshift32 step on the shared state
	function automatic logic [31:0] rand_word();
		logic [31:0] x;
		x = rng;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng = x;
		return x;
	endfunction

	task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[ERROR] %s expected 0x%08h actual 0x%08h", name, exp, act);
		end
	endtask

	function automatic void model_store(input cpu_pkg::mem_op_e op, input logic [31:0] addr,
		input logic [31:0] data);
		int unsigned a;
		a = addr % MEM_BYTES;
		case (op)
			cpu_pkg::OP_SB: ref_mem[a] = data[7:0];
			cpu_pkg::OP_SH: begin
				if (!a[0]) begin                   // Misaligned half leaves memory alone
					ref_mem[a]     = data[7:0];
					ref_mem[a + 1] = data[15:8];
				end
			end
			cpu_pkg::OP_SW: begin
				for (int b = 0; b < 4; b++)
					ref_mem[(a & 32'hFFFF_FFFC) + b] = data[b*8 +: 8];
			end
			default: ;
		endcase
	endfunction

	function automatic logic [31:0] model_load(input cpu_pkg::mem_op_e op,
		input logic [31:0] addr);
		int unsigned a;
		logic [7:0]  bt;
		logic [15:0] hw;
		logic [31:0] res;
		a   = addr % MEM_BYTES;
		bt  = ref_mem[a];
		res = '0;                              // Misaligned half or word reads zero
		case (op)
			cpu_pkg::OP_LB:  res = {{24{bt[7]}}, bt};
			cpu_pkg::OP_LBU: res = {24'b0, bt};
			cpu_pkg::OP_LH, cpu_pkg::OP_LHU: begin
				if (!a[0]) begin
					hw  = {ref_mem[a + 1], ref_mem[a]};
					res = (op == cpu_pkg::OP_LH) ? {{16{hw[15]}}, hw} : {16'b0, hw};
				end
			end
			cpu_pkg::OP_LW: begin
				if (a[1:0] == 2'b00)
					res = {ref_mem[a + 3], ref_mem[a + 2], ref_mem[a + 1], ref_mem[a]};
			end
			default: ;
		endcase
		return res;
	endfunction

	// Appends a row with expected values from the byte model in program order
	function automatic void add_entry(input string name, input cpu_pkg::mem_op_e op,
		input logic [31:0] addr, input logic [31:0] wdata, input logic [4:0] rd,
		input logic rd_we);
		row_t r;
		r.op       = op;
		r.addr     = addr;
		r.wdata    = wdata;
		r.rd       = rd;
		r.rd_we    = rd_we;
		r.exp_bus  = 1'b0;
		r.exp_we   = rd_we;
		r.exp_data = wdata;                    // Pass-through result
		case (op)
			cpu_pkg::OP_LB, cpu_pkg::OP_LH, cpu_pkg::OP_LW,
			cpu_pkg::OP_LBU, cpu_pkg::OP_LHU: begin
				r.exp_bus  = 1'b1;
				r.exp_data = model_load(op, addr);
			end
			cpu_pkg::OP_SB, cpu_pkg::OP_SH, cpu_pkg::OP_SW: begin
				r.exp_bus = (op != cpu_pkg::OP_SH) || !addr[0];
				r.exp_we  = 1'b0;                  // Stores never write a register
				model_store(op, addr, wdata);
			end
			default: ;
		endcase
		tbl.push_back(r);
		tbl_name.push_back(name);
	endfunction

	task automatic build_table();
		logic [31:0] d;
		add_entry("nop_first", cpu_pkg::OP_NOP, 32'h0, rand_word(), 5'd1, 1'b1);
		add_entry("nop_no_we", cpu_pkg::OP_NOP, 32'h10, rand_word(), 5'd2, 1'b0);
		add_entry("lw_unwritten", cpu_pkg::OP_LW, 32'h40, rand_word(), 5'd3, 1'b1);
		add_entry("lw_unwritten_top", cpu_pkg::OP_LW, 32'h3FC, 32'h0, 5'd4, 1'b1);
		add_entry("sw_word", cpu_pkg::OP_SW, 32'h40, rand_word(), 5'd5, 1'b1);
		add_entry("lw_word", cpu_pkg::OP_LW, 32'h40, 32'h0, 5'd6, 1'b1);
		add_entry("lw_wrap", cpu_pkg::OP_LW, 32'h440, 32'h0, 5'd7, 1'b1);  // Same word
		add_entry("nop_after_load", cpu_pkg::OP_NOP, 32'h0, rand_word(), 5'd8, 1'b1);
		for (int lane = 0; lane < 4; lane++) begin
			d = rand_word();
			d[7] = lane[0];                      // Odd lanes negative
			add_entry($sformatf("sb_lane%0d", lane), cpu_pkg::OP_SB, 32'h80 + lane, d,
				5'd0, 1'b0);
		end
		for (int lane = 0; lane < 4; lane++) begin
			add_entry($sformatf("lb_lane%0d", lane), cpu_pkg::OP_LB, 32'h80 + lane, 32'h0,
				5'd9, 1'b1);
			add_entry($sformatf("lbu_lane%0d", lane), cpu_pkg::OP_LBU, 32'h80 + lane, 32'h0,
				5'd10, 1'b1);
		end
		add_entry("lw_bytes", cpu_pkg::OP_LW, 32'h80, 32'h0, 5'd11, 1'b1);
		d = rand_word();
		d[15] = 1'b1;
		add_entry("sh_low", cpu_pkg::OP_SH, 32'hC0, d, 5'd12, 1'b1);
		d = rand_word();
		d[15] = 1'b0;
		add_entry("sh_high", cpu_pkg::OP_SH, 32'hC2, d, 5'd13, 1'b1);
		add_entry("lh_low", cpu_pkg::OP_LH, 32'hC0, 32'h0, 5'd14, 1'b1);
		add_entry("lhu_low", cpu_pkg::OP_LHU, 32'hC0, 32'h0, 5'd15, 1'b1);
		add_entry("lh_high", cpu_pkg::OP_LH, 32'hC2, 32'h0, 5'd16, 1'b1);
		add_entry("lhu_high", cpu_pkg::OP_LHU, 32'hC2, 32'h0, 5'd17, 1'b1);
		add_entry("lw_halves", cpu_pkg::OP_LW, 32'hC0, 32'h0, 5'd18, 1'b1);
		add_entry("sh_misaligned", cpu_pkg::OP_SH, 32'hC1, rand_word(), 5'd19, 1'b1);
		add_entry("lw_after_bad_sh", cpu_pkg::OP_LW, 32'hC0, 32'h0, 5'd20, 1'b1);
		add_entry("lh_misaligned", cpu_pkg::OP_LH, 32'hC1, 32'h0, 5'd21, 1'b1);
		add_entry("lhu_misaligned", cpu_pkg::OP_LHU, 32'hC3, 32'h0, 5'd22, 1'b1);
		add_entry("nop_last", cpu_pkg::OP_NOP, 32'h0, rand_word(), 5'd31, 1'b1);
	endtask

	// Called on a falling edge with stall_o low and returns on the retire's falling edge
	task automatic apply_entry(input int i);
		row_t             r;
		cpu_pkg::ex_mem_t e;
		r       = tbl[i];
		e.valid = 1'b1;
		e.op    = r.op;
		e.addr  = r.addr;
		e.wdata = r.wdata;
		e.rd    = r.rd;
		e.rd_we = r.rd_we;
		ex_i    = e;                           // Accepted on the next rising edge
		@(negedge clk);
		if (r.exp_bus) begin
			check_val({tbl_name[i], " stall"}, 32'd1, 32'(stall_o));
			while (stall_o)                      // ex_i held while stalled
				@(negedge clk);
		end else begin
			check_val({tbl_name[i], " stall"}, 32'd0, 32'(stall_o));
		end
		check_val({tbl_name[i], " retire"}, 32'd1, 32'(wb_o.valid));
		check_val({tbl_name[i], " rd_we"}, 32'(r.exp_we), 32'(wb_o.rd_we));
		// Pass-through keeps its rd and data even without a register write
		if (r.exp_we || r.op == cpu_pkg::OP_NOP) begin
			check_val({tbl_name[i], " rd"}, 32'(r.rd), 32'(wb_o.rd));
			check_val({tbl_name[i], " data"}, r.exp_data, wb_o.data);
		end
	endtask

	// Counts retires and flags one that arrives during a stall
	initial begin
		forever begin
			@(negedge clk);
			if (!rst && wb_o.valid) begin
				retires++;
				if (stall_o) begin
					errors++;
					$display("Retire pulse seen while stall_o was still high");
				end
			end
		end
	end

	initial begin
		while (limit == 0 || cycles < limit) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout after %0d cycles, the DUT stopped making progress", cycles);
		$display("TEST RESULT: FAIL");
		$finish;
	end

	initial begin
		rst  = 1'b1;
		ex_i = '0;
		foreach (ref_mem[k])
			ref_mem[k] = 8'h00;
		build_table();
		limit = tbl.size() * (RAM_WAIT + 8) + 50;
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		@(negedge clk);
		check_val("reset stall", 32'd0, 32'(stall_o));
		check_val("reset retire", 32'd0, 32'(wb_o.valid));
		for (int i = 0; i < tbl.size(); i++)
			apply_entry(i);
		ex_i = '0;                             // Execute goes idle
		repeat (6) @(negedge clk);             // Room for any stray retire
		check_val("retire count", 32'(tbl.size()), 32'(retires));
		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

// ==== source/mem_subsys_top.sv ====
`timescale 1ns/1ps
`include "cpu_macros.svh"

module mem_subsys_top #(
	parameter int RAM_WAIT = `RAM_WAIT_DEFAULT
) (
	input  logic             clk,
	input  logic             rst,
	input  cpu_pkg::ex_mem_t ex_i,
	output logic             stall_o,
	output cpu_pkg::mem_wb_t wb_o
);

	cpu_pkg::mem_req_t   mem_req;   // Stage to master
	cpu_pkg::mem_rsp_t   mem_rsp;   // Master to stage
	axil_pkg::axil_req_t axil_req;  // Master to RAM
	axil_pkg::axil_rsp_t axil_rsp;  // RAM to master

	mem_stage u_stage (
		.clk     (clk),
		.rst     (rst),
		.ex_i    (ex_i),
		.stall_o (stall_o),
		.wb_o    (wb_o),
		.req_o   (mem_req),
		.rsp_i   (mem_rsp)
	);

	axil_data_master u_master (
		.clk    (clk),
		.rst    (rst),
		.req_i  (mem_req),
		.rsp_o  (mem_rsp),
		.axil_o (axil_req),
		.axil_i (axil_rsp)
	);

	// RAM latency set from the top
	axil_data_ram #(
		.WAIT_CYCLES (RAM_WAIT)
	) u_ram (
		.clk    (clk),
		.rst    (rst),
		.axil_i (axil_req),
		.axil_o (axil_rsp)
	);

endmodule

// ==== source/axil_data_ram.sv ====
`timescale 1ns/1ps
`include "cpu_macros.svh"

module axil_data_ram #(
	parameter int WAIT_CYCLES = `RAM_WAIT_DEFAULT
) (
	input  logic                clk,
	input  logic                rst,
	input  axil_pkg::axil_req_t axil_i,
	output axil_pkg::axil_rsp_t axil_o
);

	localparam int IDX_W = $clog2(`RAM_DEPTH_WORDS);
	localparam int CNT_W = $clog2(WAIT_CYCLES + 2);

	logic [`CPU_WORD_W-1:0] mem [`RAM_DEPTH_WORDS];

	logic [CNT_W-1:0]       cnt;         // Idle cycles spent on the current request
	logic                   wr_ready_q;  // Drives AWREADY and WREADY together
	logic                   ar_ready_q;
	logic                   bvalid_q;
	logic                   rvalid_q;
	logic [`CPU_WORD_W-1:0] rdata_q;
	logic                   busy;
	logic                   wr_req;
	logic                   rd_req;
	logic                   wr_beat;
	logic                   rd_beat;
	logic [IDX_W-1:0]       wr_idx;
	logic [IDX_W-1:0]       rd_idx;

	assign busy    = wr_ready_q || ar_ready_q || bvalid_q || rvalid_q;
	assign wr_req  = axil_i.awvalid && axil_i.wvalid;  // Both beats needed before ready
	assign rd_req  = axil_i.arvalid;
	assign wr_beat = wr_ready_q && wr_req;
	assign rd_beat = ar_ready_q && rd_req;

	// Word index, upper address bits dropped so it wraps
	assign wr_idx = axil_i.awaddr[IDX_W+1:2];
	assign rd_idx = axil_i.araddr[IDX_W+1:2];

	always_ff @(posedge clk) begin
		if (rst) begin
			cnt        <= '0;
			wr_ready_q <= 1'b0;
			ar_ready_q <= 1'b0;
			bvalid_q   <= 1'b0;
			rvalid_q   <= 1'b0;
		end else begin
			wr_ready_q <= 1'b0;                          // Ready is a one-cycle pulse
			ar_ready_q <= 1'b0;
			if (bvalid_q && axil_i.bready)
				bvalid_q <= 1'b0;
			if (rvalid_q && axil_i.rready)
				rvalid_q <= 1'b0;
			if (wr_beat)
				bvalid_q <= 1'b1;                          // B one cycle after AW/W
			if (rd_beat)
				rvalid_q <= 1'b1;                          // R one cycle after AR
			if (!busy && (wr_req || rd_req)) begin
				if (cnt == CNT_W'(WAIT_CYCLES)) begin
					cnt <= '0;
					if (wr_req)
						wr_ready_q <= 1'b1;                    // Writes win over reads
					else
						ar_ready_q <= 1'b1;
				end else begin
					cnt <= cnt + 1'b1;
				end
			end
		end
	end

	// Storage, byte-lane write merge
	always_ff @(posedge clk) begin
		if (wr_beat) begin
			for (int b = 0; b < `CPU_WORD_W/8; b++) begin
				if (axil_i.wstrb[b])
					mem[wr_idx][b*8 +: 8] <= axil_i.wdata[b*8 +: 8];
			end
		end
		if (rd_beat)
			rdata_q <= mem[rd_idx];                      // Whole word, stage picks the lane
	end

	always_comb begin
		axil_o.awready = wr_ready_q;
		axil_o.wready  = wr_ready_q;
		axil_o.bvalid  = bvalid_q;
		axil_o.bresp   = 2'b00;                        // OKAY
		axil_o.arready = ar_ready_q;
		axil_o.rvalid  = rvalid_q;
		axil_o.rdata   = rdata_q;
		axil_o.rresp   = 2'b00;
	end

endmodule

// ==== source/axil_data_master.sv ====
`timescale 1ns/1ps

module axil_data_master (
	input  logic                clk,
	input  logic                rst,
	input  cpu_pkg::mem_req_t   req_i,
	output cpu_pkg::mem_rsp_t   rsp_o,
	output axil_pkg::axil_req_t axil_o,
	input  axil_pkg::axil_rsp_t axil_i
);

	axil_pkg::axil_state_e state;

	logic aw_pend;   // AW beat not yet taken
	logic w_pend;    // W beat not yet taken
	logic aw_left;
	logic w_left;
	logic done_q;
	logic [$bits(req_i.wdata)-1:0] rdata_q;

	// Beats still outstanding after this edge
	assign aw_left = aw_pend && !axil_i.awready;
	assign w_left  = w_pend && !axil_i.wready;

	always_ff @(posedge clk) begin
		if (rst) begin
			state   <= axil_pkg::ST_IDLE;
			aw_pend <= 1'b0;
			w_pend  <= 1'b0;
			done_q  <= 1'b0;
		end else begin
			done_q <= 1'b0;
			case (state)
				axil_pkg::ST_IDLE: begin
					// Request is still up during the done cycle, skip it
					if (req_i.valid && !done_q) begin
						if (req_i.write) begin
							state   <= axil_pkg::ST_WRITE;
							aw_pend <= 1'b1;
							w_pend  <= 1'b1;
						end else begin
							state <= axil_pkg::ST_READ;
						end
					end
				end
				axil_pkg::ST_WRITE: begin
					aw_pend <= aw_left;                     // Address and data in any order
					w_pend  <= w_left;
					if (!aw_left && !w_left)
						state <= axil_pkg::ST_WRESP;
				end
				axil_pkg::ST_WRESP: begin
					if (axil_i.bvalid) begin
						state  <= axil_pkg::ST_IDLE;
						done_q <= 1'b1;                     // bresp ignored
					end
				end
				axil_pkg::ST_READ: begin
					if (axil_i.arready)
						state <= axil_pkg::ST_RDATA;
				end
				axil_pkg::ST_RDATA: begin
					if (axil_i.rvalid) begin
						state  <= axil_pkg::ST_IDLE;
						done_q <= 1'b1;
					end
				end
				default: state <= axil_pkg::ST_IDLE;
			endcase
		end
	end

	// Read data capture on the R beat
	always_ff @(posedge clk) begin
		if (state == axil_pkg::ST_RDATA && axil_i.rvalid)
			rdata_q <= axil_i.rdata;
	end

	// Payload straight from the held request, handshakes from state
	always_comb begin
		axil_o.awaddr  = req_i.addr;
		axil_o.wdata   = req_i.wdata;
		axil_o.wstrb   = req_i.wstrb;
		axil_o.araddr  = req_i.addr;
		axil_o.awvalid = (state == axil_pkg::ST_WRITE) && aw_pend;
		axil_o.wvalid  = (state == axil_pkg::ST_WRITE) && w_pend;
		axil_o.bready  = (state == axil_pkg::ST_WRESP);
		axil_o.arvalid = (state == axil_pkg::ST_READ);
		axil_o.rready  = (state == axil_pkg::ST_RDATA);
	end

	assign rsp_o.done  = done_q;
	assign rsp_o.rdata = rdata_q;

endmodule

// ==== source/mem_stage.sv ====
`timescale 1ns/1ps
`include "cpu_macros.svh"

module mem_stage (
	input  logic              clk,
	input  logic              rst,
	input  cpu_pkg::ex_mem_t  ex_i,
	output logic              stall_o,
	output cpu_pkg::mem_wb_t  wb_o,
	output cpu_pkg::mem_req_t req_o,
	input  cpu_pkg::mem_rsp_t rsp_i
);

	typedef enum logic {
		S_IDLE,  // Slot free, accepting from execute
		S_BUSY   // Bus access in flight, execute held
	} stage_state_e;

	stage_state_e state;

	logic accept;
	logic is_load;
	logic is_store;
	logic bus_access;
	logic [`CPU_WORD_W-1:0]   st_data;
	logic [`CPU_WORD_W/8-1:0] st_strb;

	// Latched instruction info for load extraction
	cpu_pkg::mem_op_e lat_op;
	logic [1:0]       lat_off;

	// Request payload held toward the master
	logic                     req_write;
	logic [`CPU_WORD_W-1:0]   req_addr;
	logic [`CPU_WORD_W-1:0]   req_wdata;
	logic [`CPU_WORD_W/8-1:0] req_strb;

	// Retire register
	logic                       wb_valid;
	logic [`CPU_REG_ADDR_W-1:0] wb_rd;
	logic                       wb_rd_we;
	logic [`CPU_WORD_W-1:0]     wb_data;

	logic [7:0]             ld_byte;
	logic [15:0]            ld_half;
	logic [`CPU_WORD_W-1:0] ld_data;

	assign stall_o = (state == S_BUSY);          // Registered, no comb path from ex_i
	assign accept  = ex_i.valid && !stall_o;

	// Op class decode
	always_comb begin
		is_load  = 1'b0;
		is_store = 1'b0;
		case (ex_i.op)
			cpu_pkg::OP_LB, cpu_pkg::OP_LH, cpu_pkg::OP_LW,
			cpu_pkg::OP_LBU, cpu_pkg::OP_LHU: is_load = 1'b1;
			cpu_pkg::OP_SB, cpu_pkg::OP_SH, cpu_pkg::OP_SW: is_store = 1'b1;
			default: ;                                // NOP and unknown ops pass through
		endcase
	end

	// Store lane replication and strobe
	always_comb begin
		st_data = ex_i.wdata;
		st_strb = '0;
		case (ex_i.op)
			cpu_pkg::OP_SB: begin
				st_data = {4{ex_i.wdata[7:0]}};
				st_strb = 4'b0001 << ex_i.addr[1:0];      // One lane per byte offset
			end
			cpu_pkg::OP_SH: begin
				st_data = {2{ex_i.wdata[15:0]}};
				if (!ex_i.addr[0])
					st_strb = 4'b0011 << ex_i.addr[1:0];  // Low or high half
			end
			cpu_pkg::OP_SW: st_strb = 4'b1111;
			default: ;
		endcase
	end

	// Empty strobe means misaligned SH, retired with no bus transfer
	assign bus_access = is_load || (is_store && (st_strb != '0));

	// Load lane select on the returned word
	assign ld_byte = rsp_i.rdata[{lat_off, 3'b000} +: 8];
	assign ld_half = rsp_i.rdata[{lat_off[1], 4'b0000} +: 16];

	always_comb begin
		ld_data = '0;                                 // Stores and misaligned loads give zero
		case (lat_op)
			cpu_pkg::OP_LB:  ld_data = {{(`CPU_WORD_W-8){ld_byte[7]}}, ld_byte};
			cpu_pkg::OP_LBU: ld_data = {{(`CPU_WORD_W-8){1'b0}}, ld_byte};
			cpu_pkg::OP_LH: begin
				if (!lat_off[0])
					ld_data = {{(`CPU_WORD_W-16){ld_half[15]}}, ld_half};
			end
			cpu_pkg::OP_LHU: begin
				if (!lat_off[0])
					ld_data = {{(`CPU_WORD_W-16){1'b0}}, ld_half};
			end
			cpu_pkg::OP_LW: begin
				if (lat_off == 2'b00)
					ld_data = rsp_i.rdata;
			end
			default: ;
		endcase
	end

	// Slot control
	always_ff @(posedge clk) begin
		if (rst) begin
			state    <= S_IDLE;
			wb_valid <= 1'b0;
		end else begin
			wb_valid <= 1'b0;                          // Single-cycle retire pulse
			case (state)
				S_IDLE: begin
					if (accept) begin
						if (bus_access)
							state <= S_BUSY;
						else
							wb_valid <= 1'b1;              // Pass-through retires next cycle
					end
				end
				S_BUSY: begin
					if (rsp_i.done) begin
						state    <= S_IDLE;
						wb_valid <= 1'b1;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// Payload capture
	always_ff @(posedge clk) begin
		if (accept) begin
			lat_op    <= ex_i.op;
			lat_off   <= ex_i.addr[1:0];
			req_write <= is_store;
			req_addr  <= {ex_i.addr[`CPU_WORD_W-1:2], 2'b00};
			req_wdata <= st_data;
			req_strb  <= st_strb;
			wb_rd     <= ex_i.rd;
			wb_rd_we  <= ex_i.rd_we && !is_store;      // Stores never write a register
			wb_data   <= is_store ? '0 : ex_i.wdata;
		end else if (stall_o && rsp_i.done) begin
			wb_data   <= ld_data;
		end
	end

	always_comb begin
		req_o.valid = stall_o;
		req_o.write = req_write;
		req_o.addr  = req_addr;
		req_o.wdata = req_wdata;
		req_o.wstrb = req_strb;
	end

	always_comb begin
		wb_o.valid = wb_valid;
		wb_o.rd    = wb_rd;
		wb_o.rd_we = wb_rd_we;
		wb_o.data  = wb_data;
	end

endmodule

// ==== source/axil_pkg.sv ====
`include "cpu_macros.svh"

package axil_pkg;

	// Channels driven by the master
	typedef struct packed {
		logic [`CPU_WORD_W-1:0]    awaddr;
		logic                      awvalid;
		logic [`CPU_WORD_W-1:0]    wdata;
		logic [`CPU_WORD_W/8-1:0]  wstrb;
		logic                      wvalid;
		logic                      bready;
		logic [`CPU_WORD_W-1:0]    araddr;
		logic                      arvalid;
		logic                      rready;
	} axil_req_t;

	// Channels driven by the slave
	typedef struct packed {
		logic                      awready;
		logic                      wready;
		logic                      bvalid;
		logic [1:0]                bresp;    // Always OKAY here
		logic                      arready;
		logic                      rvalid;
		logic [`CPU_WORD_W-1:0]    rdata;
		logic [1:0]                rresp;    // Always OKAY here
	} axil_rsp_t;

	// Bus master sequencing
	typedef enum logic [2:0] {
		ST_IDLE  = 3'd0,  // Waiting for a stage request
		ST_WRITE = 3'd1,  // AW and W beats outstanding
		ST_WRESP = 3'd2,  // Waiting on B
		ST_READ  = 3'd3,  // AR beat outstanding
		ST_RDATA = 3'd4   // Waiting on R
	} axil_state_e;

endpackage

// ==== source/cpu_pkg.sv ====
`include "cpu_macros.svh"

package cpu_pkg;

	// Memory operation carried from execute
	typedef enum logic [3:0] {
		OP_NOP = 4'd0,   // Register write pass-through only
		OP_LB  = 4'd1,
		OP_LH  = 4'd2,
		OP_LW  = 4'd3,
		OP_LBU = 4'd4,
		OP_LHU = 4'd5,
		OP_SB  = 4'd6,
		OP_SH  = 4'd7,
		OP_SW  = 4'd8
	} mem_op_e;

	// Execute to memory stage
	typedef struct packed {
		logic                        valid;
		mem_op_e                     op;
		logic [`CPU_WORD_W-1:0]      addr;   // Byte address
		logic [`CPU_WORD_W-1:0]      wdata;  // Store data or ALU result
		logic [`CPU_REG_ADDR_W-1:0]  rd;
		logic                        rd_we;
	} ex_mem_t;

	// Memory stage to write-back
	typedef struct packed {
		logic                        valid;
		logic [`CPU_REG_ADDR_W-1:0]  rd;
		logic                        rd_we;
		logic [`CPU_WORD_W-1:0]      data;
	} mem_wb_t;

	// Stage to bus master, held until done
	typedef struct packed {
		logic                        valid;
		logic                        write;
		logic [`CPU_WORD_W-1:0]      addr;   // Word aligned
		logic [`CPU_WORD_W-1:0]      wdata;  // Lane-replicated store data
		logic [`CPU_WORD_W/8-1:0]    wstrb;
	} mem_req_t;

	// Bus master back to stage
	typedef struct packed {
		logic                        done;   // One-cycle completion pulse
		logic [`CPU_WORD_W-1:0]      rdata;  // Valid with done on reads
	} mem_rsp_t;

endpackage

// ==== source/cpu_macros.svh ====
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// Data path and byte address width
`define CPU_WORD_W 32

// Register file index width (x0..x31)
`define CPU_REG_ADDR_W 5

// Data RAM size in 32-bit words
// Kept a power of two so the word index wraps by truncation
`define RAM_DEPTH_WORDS 256

// Idle cycles the RAM inserts before each ready
`define RAM_WAIT_DEFAULT 2

`endif
